// File: hw/collect_pkg.sv
package collect_pkg;

	localparam int DATA_W     = 64;
	localparam int BYTE_W     = DATA_W / 8;
	localparam int DEST_W     = 8;
	localparam int LANES      = 4;
	localparam int LANE_W     = $clog2(LANES);
	localparam int FIFO_DEPTH = 16;
	localparam int PTR_W      = $clog2(FIFO_DEPTH);
	localparam int CNT_W      = PTR_W + 1; // Must reach FIFO_DEPTH

	// One beat as seen on the receive port
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [BYTE_W-1:0] keep;
		logic [DEST_W-1:0] dest;
		logic              last;
	} rx_beat_t;

	// Entry held in a lane FIFO, dest already consumed by routing
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [BYTE_W-1:0] keep;
		logic              last;
	} lane_word_t;

	typedef struct packed {
		logic [BYTE_W-1:0] parity;
		logic [LANE_W-1:0] lane;
		logic              last;
	} out_word_t;

endpackage

// File: hw/stream_demux.sv
`timescale 1ns/1ns

module stream_demux
	import collect_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             rx_tvalid,
	input  rx_beat_t         rx_beat,
	input  logic [LANES-1:0] lane_full,
	output logic             rx_tready,
	output logic [LANES-1:0] lane_push,
	output lane_word_t       lane_word
);

	logic [LANE_W-1:0] sel;
	logic              ready_en;
	logic              accept;

	// Held low through reset, released on the first edge after it
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_en <= 1'b0;
		end else begin
			ready_en <= 1'b1;
		end
	end

	assign sel = rx_beat.dest[LANE_W-1:0]; // Low dest bits name the lane

	assign rx_tready = ready_en & ~rst & ~lane_full[sel];
	assign accept    = rx_tvalid & rx_tready;

	always_comb begin
		lane_push = '0;
		if (accept) begin
			lane_push[sel] = 1'b1;
		end
	end

	// Same word goes to every lane, only the push picks the taker
	always_comb begin
		lane_word.data = rx_beat.data;
		lane_word.keep = rx_beat.keep;
		lane_word.last = rx_beat.last;
	end

endmodule

// File: hw/lane_fifo.sv
`timescale 1ns/1ns

module lane_fifo
	import collect_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  lane_word_t       wdata,
	input  logic             pop,
	output lane_word_t       rdata,
	output logic             empty,
	output logic             full,
	output logic [CNT_W-1:0] last_count
);

	lane_word_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] head_ptr;
	logic [PTR_W-1:0] tail_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;
	logic             push_last;
	logic             pop_last;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(FIFO_DEPTH)); // All slots usable

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign push_last = do_push & wdata.last;
	assign pop_last  = do_pop & rdata.last;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[tail_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_ptr   <= '0;
			tail_ptr   <= '0;
			count      <= '0;
			last_count <= '0;
		end else begin
			if (do_push) begin
				tail_ptr <= tail_ptr + 1'b1; // Wraps at FIFO_DEPTH
			end
			if (do_pop) begin
				head_ptr <= head_ptr + 1'b1;
			end

			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end

			// Complete frames waiting in this FIFO
			if (push_last && !pop_last) begin
				last_count <= last_count + 1'b1;
			end else if (pop_last && !push_last) begin
				last_count <= last_count - 1'b1;
			end
		end
	end

	assign rdata = mem[head_ptr];

endmodule

// File: hw/parity_lane.sv
`timescale 1ns/1ns

module parity_lane
	import collect_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  lane_word_t wdata,
	input  logic       pop,
	output logic       full,
	output logic       head_valid,
	output logic       frame_done,
	output out_word_t  head
);

	lane_word_t       rdata;
	logic             empty;
	logic [CNT_W-1:0] last_count;

	lane_fifo u_fifo (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.wdata      (wdata),
		.pop        (pop),
		.rdata      (rdata),
		.empty      (empty),
		.full       (full),
		.last_count (last_count)
	);

	assign head_valid = ~empty;
	assign frame_done = (last_count != '0);

	// One parity bit per byte, masked bytes read as 0
	always_comb begin
		for (int i = 0; i < BYTE_W; i++) begin
			head.parity[i] = (^rdata.data[i*8 +: 8]) & rdata.keep[i];
		end
		head.lane = '0; // Filled in by the arbiter
		head.last = rdata.last;
	end

endmodule

// File: hw/drain_arbiter.sv
`timescale 1ns/1ns

module drain_arbiter
	import collect_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic      [LANES-1:0] head_valid,
	input  logic      [LANES-1:0] frame_done,
	input  out_word_t [LANES-1:0] heads,
	output logic      [LANES-1:0] lane_pop,
	input  logic                  ofifo_ren,
	output logic                  ofifo_rdy,
	output out_word_t             ofifo_word
);

	logic              busy;
	logic [LANE_W-1:0] cur_lane;
	logic [LANE_W-1:0] rr_ptr;    // Last lane served
	logic [LANE_W-1:0] next_lane;
	logic              found;
	logic              pop_now;

	// First complete lane after the last one served
	always_comb begin
		logic [LANE_W-1:0] idx;
		next_lane = rr_ptr;
		found     = 1'b0;
		for (int k = 1; k <= LANES; k++) begin
			idx = rr_ptr + LANE_W'(k);
			if (!found && frame_done[idx]) begin
				next_lane = idx;
				found     = 1'b1;
			end
		end
	end

	assign ofifo_rdy = busy & head_valid[cur_lane];
	assign pop_now   = ofifo_rdy & ofifo_ren;
	assign lane_pop  = pop_now ? (LANES'(1) << cur_lane) : '0;

	always_comb begin
		ofifo_word      = heads[cur_lane];
		ofifo_word.lane = cur_lane;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			cur_lane <= '0;
			rr_ptr   <= LANE_W'(LANES - 1); // Lane 0 goes first
		end else if (!busy) begin
			if (found) begin
				busy     <= 1'b1;
				cur_lane <= next_lane;
			end
		end else if (pop_now && ofifo_word.last) begin
			busy   <= 1'b0; // Frame fully drained
			rr_ptr <= cur_lane;
		end
	end

endmodule

// File: hw/collector_top.sv
`timescale 1ns/1ns

module collector_top
	import collect_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      rx_tvalid,
	input  rx_beat_t  rx_beat,
	output logic      rx_tready,
	input  logic      ofifo_ren,
	output logic      ofifo_rdy,
	output out_word_t ofifo_word
);

	logic      [LANES-1:0] lane_full;
	logic      [LANES-1:0] lane_push;
	lane_word_t            lane_word;
	logic      [LANES-1:0] head_valid;
	logic      [LANES-1:0] frame_done;
	out_word_t [LANES-1:0] heads;
	logic      [LANES-1:0] lane_pop;

	stream_demux u_demux (
		.clk       (clk),
		.rst       (rst),
		.rx_tvalid (rx_tvalid),
		.rx_beat   (rx_beat),
		.lane_full (lane_full),
		.rx_tready (rx_tready),
		.lane_push (lane_push),
		.lane_word (lane_word)
	);

	for (genvar g = 0; g < LANES; g++) begin : gen_lane
		parity_lane u_lane (
			.clk        (clk),
			.rst        (rst),
			.push       (lane_push[g]),
			.wdata      (lane_word),
			.pop        (lane_pop[g]),
			.full       (lane_full[g]),
			.head_valid (head_valid[g]),
			.frame_done (frame_done[g]),
			.head       (heads[g])
		);
	end

	drain_arbiter u_arb (
		.clk        (clk),
		.rst        (rst),
		.head_valid (head_valid),
		.frame_done (frame_done),
		.heads      (heads),
		.lane_pop   (lane_pop),
		.ofifo_ren  (ofifo_ren),
		.ofifo_rdy  (ofifo_rdy),
		.ofifo_word (ofifo_word)
	);

endmodule

// File: test/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
	output logic clk
);

	localparam int HALF_PERIOD = 50; // 100 ns clock

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// File: test/collector_props.sv
`timescale 1ns/1ns

module collector_props
	import collect_pkg::*;
(
	input logic             clk,
	input logic             rst,
	input rx_beat_t         rx_beat,
	input logic             rx_tready,
	input logic [LANES-1:0] lane_full,
	input logic             ofifo_rdy,
	input logic             ofifo_ren,
	input out_word_t        ofifo_word
);

	int unsigned fail_count = 0;

	// A waiting output word holds until it is taken
	hold_word: assert property (@(posedge clk) disable iff (rst)
		ofifo_rdy && !ofifo_ren |=> ofifo_rdy && $stable(ofifo_word))
	else begin
		fail_count++;
		$error("ofifo_word moved while waiting for ofifo_ren");
	end

	quiet_reset: assert property (@(posedge clk) $past(rst) || $past(rst, 2) |-> !ofifo_rdy)
	else begin
		fail_count++;
		$error("ofifo_rdy high during or just after reset");
	end

	full_blocks: assert property (@(posedge clk) disable iff (rst)
		lane_full[rx_beat.dest[LANE_W-1:0]] |-> !rx_tready)
	else begin
		fail_count++;
		$error("rx_tready high for a beat addressed to a full lane");
	end

endmodule

bind collector_top collector_props props_i (
	.clk        (clk),
	.rst        (rst),
	.rx_beat    (rx_beat),
	.rx_tready  (rx_tready),
	.lane_full  (lane_full),
	.ofifo_rdy  (ofifo_rdy),
	.ofifo_ren  (ofifo_ren),
	.ofifo_word (ofifo_word)
);

// File: test/collector_tb.sv
`timescale 1ns/1ns

module collector_tb
	import collect_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 6000;
	localparam int RANDOM_FRAMES  = 450;

	logic              clk;
	logic              rst = 1'b1;
	logic              rx_tvalid = 1'b0;
	rx_beat_t          rx_beat = '0;
	logic              rx_tready;
	logic              ofifo_ren;
	logic              ofifo_rdy;
	out_word_t         ofifo_word;
	int                seed = 32'hcab563fe;
	int                cycles = 0;
	int                pending = 0;
	string             test_name = "reset";
	logic              drain_on = 1'b0;
	logic              ren_gap = 1'b0;
	logic              rr_check = 1'b0;
	logic              in_frame = 1'b0;
	logic [LANE_W-1:0] frame_lane = '0;
	logic [LANE_W-1:0] last_served = LANE_W'(LANES - 1);
	out_word_t         exp_q [LANES][$]; // Expected words per lane, oldest first

	clk_gen clk_i (.clk(clk));

	collector_top dut_i (
		.clk        (clk),
		.rst        (rst),
		.rx_tvalid  (rx_tvalid),
		.rx_beat    (rx_beat),
		.rx_tready  (rx_tready),
		.ofifo_ren  (ofifo_ren),
		.ofifo_rdy  (ofifo_rdy),
		.ofifo_word (ofifo_word)
	);

	// XOR of the bits of each kept byte
	function automatic logic [BYTE_W-1:0] fold_parity(input logic [DATA_W-1:0] data,
		input logic [BYTE_W-1:0] keep);
		logic [BYTE_W-1:0] p;
		p = '0;
		for (int b = 0; b < DATA_W; b++) begin
			if (keep[b / 8]) p[b / 8] = p[b / 8] ^ data[b];
		end
		return p;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic drive_beat(input logic [LANE_W-1:0] lane, input logic last);
		rx_beat.data = {$random(seed), $random(seed)};
		rx_beat.keep = BYTE_W'($random(seed));
		rx_beat.dest = DEST_W'($random(seed));
		rx_beat.dest[LANE_W-1:0] = lane;
		rx_beat.last = last;
		rx_tvalid = 1'b1;
	endtask

	task automatic send_frame(input logic [LANE_W-1:0] lane, input int len);
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			drive_beat(lane, i == len - 1);
			@(posedge clk);
			while (!rx_tready) @(posedge clk);
		end
		@(negedge clk);
		rx_tvalid = 1'b0;
	endtask

	task automatic wait_drained();
		while (pending != 0) @(negedge clk);
	endtask

	always @(negedge clk) ren_gap = (cycles % 4 != 3); // One pop slot in four skipped
	assign ofifo_ren = drain_on & ren_gap;

	always @(posedge clk) begin
		out_word_t         got;
		out_word_t         want;
		logic [LANE_W-1:0] rr_lane;
		if (!rst && rx_tvalid && rx_tready) begin
			want.parity = fold_parity(rx_beat.data, rx_beat.keep);
			want.lane   = rx_beat.dest[LANE_W-1:0];
			want.last   = rx_beat.last;
			exp_q[want.lane].push_back(want);
			pending++;
		end
		if (!rst && ofifo_rdy && ofifo_ren) begin
			got     = ofifo_word;
			rr_lane = last_served + 1'b1;
			assert (exp_q[got.lane].size() > 0) else
				fail_run($sformatf("Word popped from lane %0d with nothing expected there", got.lane));
			want = exp_q[got.lane].pop_front();
			pending--;
			assert (got == want) else
				fail_run($sformatf("Mismatch in %s: expected %h, got %h", test_name, want, got));
			assert (!in_frame || got.lane == frame_lane) else
				fail_run($sformatf("Mismatch in %s: expected lane %0d inside frame, got %0d",
					test_name, frame_lane, got.lane));
			assert (in_frame || !rr_check || got.lane == rr_lane) else
				fail_run($sformatf("Mismatch in %s: expected frame from lane %0d, got %0d",
					test_name, rr_lane, got.lane));
			in_frame   = !got.last;
			frame_lane = got.lane;
			if (got.last) last_served = got.lane;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("Timeout after %0d cycles", cycles));
		end else if (dut_i.props_i.fail_count != 0) begin
			fail_run("A bound protocol assertion failed");
		end
	end

	initial begin
		int first;
		repeat (10) begin
			@(negedge clk);
			assert (!ofifo_rdy && !rx_tready) else
				fail_run("Output or receive handshake active during reset");
		end
		rst = 1'b0;
		@(negedge clk);
		assert (!ofifo_rdy) else fail_run("ofifo_rdy high in the first cycle after reset");
		while (!rx_tready) @(negedge clk);

		test_name = "random";
		drain_on  = 1'b1;
		repeat (RANDOM_FRAMES) send_frame(LANE_W'($random(seed)), 1 + $unsigned($random(seed)) % 4);
		wait_drained();

		// Complete frames in every lane before the drain starts
		test_name = "fairness";
		send_frame(LANE_W'(1), 1); // Lane 2 is next in turn, so the order has to wrap
		wait_drained();
		drain_on  = 1'b0;
		first     = last_served + 1;
		for (int k = 0; k < LANES; k++) begin
			send_frame(LANE_W'(first + k), 1 + $unsigned($random(seed)) % 4);
		end
		rr_check = 1'b1;
		drain_on = 1'b1;
		wait_drained();
		rr_check = 1'b0;

		test_name = "backpressure";
		drain_on  = 1'b0;
		first     = $unsigned($random(seed)) % LANES;
		send_frame(LANE_W'(first), FIFO_DEPTH);
		@(negedge clk);
		drive_beat(LANE_W'(first), 1'b1);
		@(posedge clk);
		assert (!rx_tready) else fail_run("rx_tready stayed high for a full lane");
		@(negedge clk);
		drive_beat(LANE_W'(first + 1), 1'b1);
		@(posedge clk);
		assert (rx_tready) else fail_run("rx_tready low for a lane with free space");
		@(negedge clk);
		rx_tvalid = 1'b0;
		drain_on  = 1'b1;
		wait_drained();

		if (pending == 0 && dut_i.props_i.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			fail_run("Expected words were not delivered or a bound assertion failed");
		end
	end

endmodule

// File: vlog.f
hw/collect_pkg.sv
hw/stream_demux.sv
hw/lane_fifo.sv
hw/parity_lane.sv
hw/drain_arbiter.sv
hw/collector_top.sv
test/clk_gen.sv
test/collector_props.sv
test/collector_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= collector_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
